/* compile.f */
hdl/axi_chan_pkg.sv
hdl/mem_port_pkg.sv
hdl/rd_burst_gen.sv
hdl/wr_burst_gen.sv
hdl/beat_arbiter.sv
hdl/resp_fifo.sv
hdl/resp_router.sv
hdl/axi_to_mem.sv
testbench/axi_to_mem_chk.sv
testbench/tb_axi_to_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_axi_to_mem -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "all tests passed" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

/* testbench/tb_axi_to_mem.sv */
// Testbench for the AXI to memory bridge
// LFSR stimulus, byte-addressed memory model, scoreboard and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_axi_to_mem;
  import axi_chan_pkg::*;
  import mem_port_pkg::*;

  localparam int unsigned NumTxn   = 32;
  localparam longint      LimitNs  = 64'd200 * NumTxn * 20;

  logic clk_i, rst_ni;
  logic ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o, w_valid_i, w_ready_o;
  logic r_valid_o, r_ready_i, b_valid_o, b_ready_i;
  logic mem_req_valid_o, mem_gnt_i, mem_rvalid_i;
  ar_chan_t ar_i;
  aw_chan_t aw_i;
  w_chan_t  w_i;
  r_chan_t  r_o;
  b_chan_t  b_o;
  mem_req_t mem_req_o;
  data_t    mem_rdata_i;

  logic [7:0]  mem_model [65536];
  logic [7:0]  exp_mem [65536];
  logic [31:0] lfsr = 32'ha73a;
  int          errors = 0;
  int          w_count = 0;
  logic        rsp_pending = 1'b0;
  data_t       rsp_data = '0;

  ar_chan_t ar_q[$];
  aw_chan_t aw_q[$];
  w_chan_t  w_q[$];
  r_chan_t  exp_r_q[$];
  id_t      exp_b_id_q[$];
  int       exp_b_cum_q[$];
  addr_t    rd_addr_q[$];
  addr_t    wr_addr_q[$];
  int       w_total = 0;

  axi_to_mem DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [7:0] fill_byte(int a);
    return a[15:8] ^ a[7:0] ^ 8'h5a;
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic add_write(addr_t addr, len_t len, id_t id);
    w_chan_t w;
    addr_t   a;
    aw_q.push_back('{addr: addr, id: id, len: len});
    for (int b = 0; b <= len; b++) begin
      a = addr + addr_t'(b * BeatBytes);
      w = '{data: rand_bits(32), strb: strb_t'(rand_bits(4))};
      for (int k = 0; k < 4; k++) begin
        if (w.strb[k]) exp_mem[a + k] = w.data[8*k +: 8];
      end
      w_q.push_back(w);
      wr_addr_q.push_back(a);
    end
    w_total += len + 1;
    exp_b_id_q.push_back(id);
    exp_b_cum_q.push_back(w_total);
  endtask

  task automatic add_read(addr_t addr, len_t len, id_t id);
    addr_t a;
    ar_q.push_back('{addr: addr, id: id, len: len});
    for (int b = 0; b <= len; b++) begin
      a = addr + addr_t'(b * BeatBytes);
      exp_r_q.push_back('{data: {exp_mem[a+3], exp_mem[a+2], exp_mem[a+1], exp_mem[a]},
                          id: id, last: (b == len)});
      rd_addr_q.push_back(a);
    end
  endtask

  task automatic wait_idle();
    while (ar_q.size() + aw_q.size() + w_q.size() + exp_r_q.size() + exp_b_id_q.size() != 0)
      @(posedge clk_i);
  endtask

  // Drive on the falling edge, sample handshakes just before the rising edge
  initial begin
    int r_stall;
    int b_stall;
    int b_cum;
    r_stall = 0;
    b_stall = 0;
    forever begin
      @(negedge clk_i);
      ar_valid_i = ar_q.size() > 0;
      ar_i = ar_valid_i ? ar_q[0] : '0;
      aw_valid_i = aw_q.size() > 0;
      aw_i = aw_valid_i ? aw_q[0] : '0;
      w_valid_i = w_q.size() > 0;
      w_i = w_valid_i ? w_q[0] : '0;
      mem_gnt_i = rand_bits(2) != 0;
      // Ready low phases of 3 to 10 cycles fill the response FIFOs
      if (r_stall > 0) begin
        r_stall--;
      end else if (rand_bits(3) == 0) begin
        r_stall = 3 + int'(rand_bits(3));
      end
      r_ready_i = (r_stall == 0);
      if (b_stall > 0) begin
        b_stall--;
      end else if (rand_bits(3) == 0) begin
        b_stall = 3 + int'(rand_bits(3));
      end
      b_ready_i = (b_stall == 0);
      mem_rvalid_i = rsp_pending;
      mem_rdata_i = rsp_data;
      rsp_pending = 1'b0;
      #9;
      if (ar_valid_i && ar_ready_o) void'(ar_q.pop_front());
      if (aw_valid_i && aw_ready_o) void'(aw_q.pop_front());
      if (w_valid_i && w_ready_o) begin
        void'(w_q.pop_front());
        w_count++;
      end
      if (mem_req_valid_o && mem_gnt_i) begin
        rsp_pending = 1'b1;
        if (mem_req_o.we && wr_addr_q.size() > 0) begin
          check_value("mem_req_o.addr", wr_addr_q.pop_front(), mem_req_o.addr);
          for (int k = 0; k < 4; k++) begin
            if (mem_req_o.strb[k]) mem_model[mem_req_o.addr + k] = mem_req_o.wdata[8*k +: 8];
          end
          rsp_data = '0;
        end else if (!mem_req_o.we && rd_addr_q.size() > 0) begin
          check_value("mem_req_o.addr", rd_addr_q.pop_front(), mem_req_o.addr);
          for (int k = 0; k < 4; k++) rsp_data[8*k +: 8] = mem_model[mem_req_o.addr + k];
        end else begin
          errors++;
          $display("[ERROR] %0t memory request with no matching beat", $time);
        end
      end
      if (r_valid_o && r_ready_i) begin
        if (exp_r_q.size() > 0) begin
          check_value("r_o.data", exp_r_q[0].data, r_o.data);
          check_value("r_o.id", exp_r_q[0].id, r_o.id);
          check_value("r_o.last", exp_r_q[0].last, r_o.last);
          void'(exp_r_q.pop_front());
        end else begin
          errors++;
          $display("[ERROR] %0t R beat arrived with none expected", $time);
        end
      end
      if (b_valid_o && b_ready_i) begin
        if (exp_b_id_q.size() > 0) begin
          check_value("b_o.id", exp_b_id_q.pop_front(), b_o.id);
          b_cum = exp_b_cum_q.pop_front();
          assert (w_count >= b_cum) else begin
            errors++;
            $display("[ERROR] %0t B response came before all W beats were taken", $time);
          end
        end else begin
          errors++;
          $display("[ERROR] %0t B response arrived with none expected", $time);
        end
      end
    end
  end

  initial begin
    #(LimitNs);
    $display("[ERROR] watchdog expired after %0d ns with transactions still open", LimitNs);
    $display("tests failed");
    $finish;
  end

  initial begin
    addr_t a;
    for (int i = 0; i < 65536; i++) begin
      mem_model[i] = fill_byte(i);
      exp_mem[i] = fill_byte(i);
    end
    {ar_valid_i, aw_valid_i, w_valid_i, r_ready_i, b_ready_i} = '0;
    {mem_gnt_i, mem_rvalid_i} = '0;
    ar_i = '0;
    aw_i = '0;
    w_i = '0;
    mem_rdata_i = '0;
    rst_ni = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    // Write then read back the same burst
    for (int i = 0; i < 4; i++) begin
      a = {3'b000, 11'(rand_bits(11)), 2'b00};
      add_write(a, len_t'(rand_bits(2)), id_t'(i));
      wait_idle();
      add_read(a, len_t'(rand_bits(2)), id_t'(i + 8));
      wait_idle();
    end
    // Reads and writes offered together in separate regions
    for (int i = 0; i < 12; i++) begin
      add_write({3'b000, 11'(rand_bits(11)), 2'b00}, len_t'(rand_bits(2)), id_t'(rand_bits(4)));
      add_read({3'b100, 11'(rand_bits(11)), 2'b00}, len_t'(rand_bits(2)), id_t'(rand_bits(4)));
    end
    wait_idle();
    repeat (4) @(posedge clk_i);
    $display("Summary: %0d scoreboard errors, %0d assertion failures, %0d W beats accepted",
             errors, DUT.i_chk.fail_cnt, w_count);
    if (errors == 0 && DUT.i_chk.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/axi_to_mem_chk.sv */
// Protocol assertions for the AXI to memory bridge, bound to the top level
`timescale 1ns/1ns
`default_nettype none

module axi_to_mem_chk (
  input wire logic                   clk_i,
  input wire logic                   rst_ni,
  input wire logic                   r_valid_o,
  input wire logic                   r_ready_i,
  input wire axi_chan_pkg::r_chan_t  r_o,
  input wire logic                   b_valid_o,
  input wire logic                   b_ready_i,
  input wire axi_chan_pkg::b_chan_t  b_o,
  input wire logic                   mem_req_valid_o,
  input wire mem_port_pkg::mem_req_t mem_req_o,
  input wire logic                   mem_gnt_i,
  input wire logic                   resp_pop_i
);
  import mem_port_pkg::*;

  int outstanding_q;
  int fail_cnt = 0;

  // Granted requests whose responses have not yet left the FIFOs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(mem_req_valid_o && mem_gnt_i) - int'(resp_pop_i);
    end
  end

  r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else begin
      fail_cnt++;
      $error("R payload changed");
    end
  b_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
    else begin
      fail_cnt++;
      $error("B payload changed");
    end
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_gnt_i |=> mem_req_valid_o && $stable(mem_req_o))
    else begin
      fail_cnt++;
      $error("memory request changed before grant");
    end
  max_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_q <= int'(RespDepth))
    else begin
      fail_cnt++;
      $error("too many outstanding requests");
    end
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !(r_valid_o || b_valid_o || mem_req_valid_o))
    else begin
      fail_cnt++;
      $error("valid output high during reset");
    end

endmodule

bind axi_to_mem axi_to_mem_chk i_chk (.*, .resp_pop_i (resp_pop));

`default_nettype wire

/* hdl/axi_to_mem.sv */
// Top level of the AXI to memory bridge
// Burst generators, beat arbiter, response FIFOs and response router
`timescale 1ns/1ns
`default_nettype none

module axi_to_mem (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ar_valid_i,
  input  axi_chan_pkg::ar_chan_t ar_i,
  output logic                   ar_ready_o,
  input  logic                   aw_valid_i,
  input  axi_chan_pkg::aw_chan_t aw_i,
  output logic                   aw_ready_o,
  input  logic                   w_valid_i,
  input  axi_chan_pkg::w_chan_t  w_i,
  output logic                   w_ready_o,
  output logic                   r_valid_o,
  output axi_chan_pkg::r_chan_t  r_o,
  input  logic                   r_ready_i,
  output logic                   b_valid_o,
  output axi_chan_pkg::b_chan_t  b_o,
  input  logic                   b_ready_i,
  output logic                   mem_req_valid_o,
  output mem_port_pkg::mem_req_t mem_req_o,
  input  logic                   mem_gnt_i,
  input  logic                   mem_rvalid_i,
  input  axi_chan_pkg::data_t    mem_rdata_i
);
  import axi_chan_pkg::*;
  import mem_port_pkg::*;

  beat_t    rd_beat;
  beat_wr_t wr_beat;
  meta_t    meta_push_data, meta_head;
  data_t    rdata_head;
  logic     rd_valid, rd_ready, wr_valid, wr_ready;
  logic     meta_push, meta_full, meta_empty, data_empty, resp_pop;

  rd_burst_gen i_rd_gen (
    .clk_i, .rst_ni, .ar_valid_i, .ar_i, .ar_ready_o,
    .beat_o (rd_beat), .valid_o (rd_valid), .ready_i (rd_ready)
  );

  wr_burst_gen i_wr_gen (
    .clk_i, .rst_ni, .aw_valid_i, .aw_i, .aw_ready_o, .w_valid_i, .w_i, .w_ready_o,
    .beat_o (wr_beat), .valid_o (wr_valid), .ready_i (wr_ready)
  );

  beat_arbiter i_arbiter (
    .clk_i, .rst_ni,
    .rd_beat_i (rd_beat), .rd_valid_i (rd_valid), .rd_ready_o (rd_ready),
    .wr_beat_i (wr_beat), .wr_valid_i (wr_valid), .wr_ready_o (wr_ready),
    .mem_req_valid_o, .mem_req_o, .mem_gnt_i,
    .meta_o (meta_push_data), .meta_valid_o (meta_push), .meta_ready_i (~meta_full)
  );

  resp_fifo #(.payload_t (meta_t), .Depth (RespDepth)) i_meta_fifo (
    .clk_i, .rst_ni, .push_i (meta_push), .data_i (meta_push_data), .full_o (meta_full),
    .pop_i (resp_pop), .data_o (meta_head), .empty_o (meta_empty)
  );

  // Outstanding requests are bounded by the meta FIFO, so this one cannot overflow
  resp_fifo #(.payload_t (data_t), .Depth (RespDepth)) i_data_fifo (
    .clk_i, .rst_ni, .push_i (mem_rvalid_i), .data_i (mem_rdata_i), .full_o (),
    .pop_i (resp_pop), .data_o (rdata_head), .empty_o (data_empty)
  );

  resp_router i_router (
    .meta_i (meta_head), .meta_empty_i (meta_empty),
    .data_i (rdata_head), .data_empty_i (data_empty), .pop_o (resp_pop),
    .r_valid_o, .r_o, .r_ready_i, .b_valid_o, .b_o, .b_ready_i
  );

endmodule

`default_nettype wire

/* hdl/resp_router.sv */
// Response router: joins metadata with memory data and steers it to R or B
`timescale 1ns/1ns
`default_nettype none

module resp_router (
  input  mem_port_pkg::meta_t    meta_i,
  input  logic                   meta_empty_i,
  input  axi_chan_pkg::data_t    data_i,
  input  logic                   data_empty_i,
  output logic                   pop_o,
  output logic                   r_valid_o,
  output axi_chan_pkg::r_chan_t  r_o,
  input  logic                   r_ready_i,
  output logic                   b_valid_o,
  output axi_chan_pkg::b_chan_t  b_o,
  input  logic                   b_ready_i
);

  logic both_avail;
  logic wr_drop;

  // Metadata and data are consumed as a pair
  assign both_avail = ~meta_empty_i & ~data_empty_i;

  assign r_valid_o = both_avail & ~meta_i.write;
  assign b_valid_o = both_avail & meta_i.write & meta_i.last;

  // Intermediate write beats produce no AXI response
  assign wr_drop = both_avail & meta_i.write & ~meta_i.last;

  assign r_o = '{data: data_i, id: meta_i.id, last: meta_i.last};
  assign b_o = '{id: meta_i.id};

  assign pop_o = (r_valid_o & r_ready_i) | (b_valid_o & b_ready_i) | wr_drop;

endmodule

`default_nettype wire

/* hdl/resp_fifo.sv */
// Registered circular-buffer FIFO with a type parameter, no fall-through
`timescale 1ns/1ns
`default_nettype none

module resp_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  // Depth is a power of two; the extra pointer bit tells full from empty
  localparam int unsigned PtrWidth = $clog2(Depth);

  payload_t          mem_q [Depth];
  logic [PtrWidth:0] wr_ptr_q, rd_ptr_q;
  logic              do_push, do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[PtrWidth] != rd_ptr_q[PtrWidth]) &&
                   (wr_ptr_q[PtrWidth-1:0] == rd_ptr_q[PtrWidth-1:0]);
  assign data_o  = mem_q[rd_ptr_q[PtrWidth-1:0]];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + {{PtrWidth{1'b0}}, 1'b1};
      if (do_pop)  rd_ptr_q <= rd_ptr_q + {{PtrWidth{1'b0}}, 1'b1};
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q[PtrWidth-1:0]] <= data_i;
  end

endmodule

`default_nettype wire

/* hdl/beat_arbiter.sv */
// Read/write beat arbiter with burst-aware priority and selection lock
// Drives the memory request port and pushes response metadata
`timescale 1ns/1ns
`default_nettype none

module beat_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mem_port_pkg::beat_t    rd_beat_i,
  input  logic                   rd_valid_i,
  output logic                   rd_ready_o,
  input  mem_port_pkg::beat_wr_t wr_beat_i,
  input  logic                   wr_valid_i,
  output logic                   wr_ready_o,
  output logic                   mem_req_valid_o,
  output mem_port_pkg::mem_req_t mem_req_o,
  input  logic                   mem_gnt_i,
  output mem_port_pkg::meta_t    meta_o,
  output logic                   meta_valid_o,
  input  logic                   meta_ready_i
);
  import axi_chan_pkg::*;
  import mem_port_pkg::*;

  // Selection: 1 picks the write side
  logic  sel_d, sel_q;
  logic  lock_q;
  logic  sel_valid, grant;
  beat_t beat;

  always_comb begin
    sel_d = sel_q;
    if (!lock_q) begin
      if (rd_valid_i ^ wr_valid_i) begin
        sel_d = wr_valid_i;
      end else if (rd_valid_i && wr_valid_i) begin
        // Single write beats go ahead of read bursts, but only after a read was served
        if (wr_beat_i.beat.last && !rd_beat_i.last && !sel_q) begin
          sel_d = 1'b1;
        end else if (wr_beat_i.beat.cont) begin
          sel_d = 1'b1;
        end else if (rd_beat_i.cont) begin
          sel_d = 1'b0;
        end else begin
          sel_d = ~sel_q;
        end
      end
    end
  end

  assign beat      = sel_d ? wr_beat_i.beat : rd_beat_i;
  assign sel_valid = sel_d ? wr_valid_i : rd_valid_i;

  // No request while the metadata FIFO is full
  assign mem_req_valid_o = sel_valid & meta_ready_i;
  assign grant           = mem_req_valid_o & mem_gnt_i;
  assign rd_ready_o      = grant & ~sel_d;
  assign wr_ready_o      = grant & sel_d;
  assign meta_valid_o    = grant;

  // Read requests carry zero data and strobes
  assign mem_req_o.addr  = beat.addr & ~addr_t'(BeatBytes - 1);
  assign mem_req_o.wdata = sel_d ? wr_beat_i.w.data : '0;
  assign mem_req_o.strb  = sel_d ? wr_beat_i.w.strb : '0;
  assign mem_req_o.we    = beat.write;

  assign meta_o = '{id: beat.id, last: beat.last, write: beat.write};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      sel_q  <= sel_d;
      lock_q <= sel_valid & ~grant;
    end
  end

endmodule

`default_nettype wire

/* hdl/wr_burst_gen.sv */
// Write burst generator: AW plus W beats become write beat descriptors with data
`timescale 1ns/1ns
`default_nettype none

module wr_burst_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   aw_valid_i,
  input  axi_chan_pkg::aw_chan_t aw_i,
  output logic                   aw_ready_o,
  input  logic                   w_valid_i,
  input  axi_chan_pkg::w_chan_t  w_i,
  output logic                   w_ready_o,
  output mem_port_pkg::beat_wr_t beat_o,
  output logic                   valid_o,
  input  logic                   ready_i
);
  import axi_chan_pkg::*;

  len_t  cnt_q;
  addr_t addr_q;
  id_t   id_q;

  always_comb begin
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    beat_o.w   = w_i;
    if (cnt_q != '0) begin
      // Continuation beat only waits for W
      valid_o     = w_valid_i;
      beat_o.beat = '{addr: addr_q, id: id_q, last: (cnt_q == len_t'(1)), write: 1'b1,
                      cont: 1'b1};
      w_ready_o   = w_valid_i & ready_i;
    end else begin
      // First beat needs address and data together
      valid_o     = aw_valid_i & w_valid_i;
      beat_o.beat = '{addr: aw_i.addr, id: aw_i.id, last: (aw_i.len == '0), write: 1'b1,
                      cont: 1'b0};
      aw_ready_o  = valid_o & ready_i;
      w_ready_o   = valid_o & ready_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (valid_o && ready_i) begin
      cnt_q <= (cnt_q != '0) ? cnt_q - len_t'(1) : aw_i.len;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_o && ready_i) begin
      if (cnt_q == '0) begin
        id_q   <= aw_i.id;
        addr_q <= (aw_i.addr & ~addr_t'(BeatBytes - 1)) + addr_t'(BeatBytes);
      end else begin
        addr_q <= addr_q + addr_t'(BeatBytes);
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/rd_burst_gen.sv */
// Read burst generator: one AR becomes len + 1 read beat descriptors
`timescale 1ns/1ns
`default_nettype none

module rd_burst_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ar_valid_i,
  input  axi_chan_pkg::ar_chan_t ar_i,
  output logic                   ar_ready_o,
  output mem_port_pkg::beat_t    beat_o,
  output logic                   valid_o,
  input  logic                   ready_i
);
  import axi_chan_pkg::*;

  len_t  cnt_q;
  addr_t addr_q;
  id_t   id_q;

  always_comb begin
    ar_ready_o = 1'b0;
    if (cnt_q != '0) begin
      // Burst in progress, beats come from the registers
      valid_o = 1'b1;
      beat_o  = '{addr: addr_q, id: id_q, last: (cnt_q == len_t'(1)), write: 1'b0, cont: 1'b1};
    end else begin
      valid_o    = ar_valid_i;
      beat_o     = '{addr: ar_i.addr, id: ar_i.id, last: (ar_i.len == '0), write: 1'b0,
                     cont: 1'b0};
      ar_ready_o = ar_valid_i & ready_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (valid_o && ready_i) begin
      cnt_q <= (cnt_q != '0) ? cnt_q - len_t'(1) : ar_i.len;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_o && ready_i) begin
      if (cnt_q == '0) begin
        id_q   <= ar_i.id;
        addr_q <= (ar_i.addr & ~addr_t'(BeatBytes - 1)) + addr_t'(BeatBytes);
      end else begin
        addr_q <= addr_q + addr_t'(BeatBytes);
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_port_pkg.sv */
// Memory request struct, beat descriptors and response metadata
`default_nettype none

package mem_port_pkg;

  // Outstanding memory requests, also the depth of both response FIFOs
  localparam int unsigned RespDepth = 4;

  typedef struct packed {
    axi_chan_pkg::addr_t addr;
    axi_chan_pkg::data_t wdata;
    axi_chan_pkg::strb_t strb;
    logic                we;
  } mem_req_t;

  // cont is set on every beat after the first of a burst
  typedef struct packed {
    axi_chan_pkg::addr_t addr;
    axi_chan_pkg::id_t   id;
    logic                last;
    logic                write;
    logic                cont;
  } beat_t;

  typedef struct packed {beat_t beat; axi_chan_pkg::w_chan_t w;} beat_wr_t;

  typedef struct packed {axi_chan_pkg::id_t id; logic last; logic write;} meta_t;

endpackage

`default_nettype wire

/* hdl/axi_chan_pkg.sv */
// AXI channel widths and payload structs for AR, AW, W, R and B
`default_nettype none

package axi_chan_pkg;

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned LenWidth  = 8;
  // Address step between consecutive full-width beats
  localparam int unsigned BeatBytes = DataWidth / 8;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [DataWidth/8-1:0] strb_t;
  typedef logic [IdWidth-1:0]     id_t;
  // Beats in a burst are len + 1
  typedef logic [LenWidth-1:0]    len_t;

  typedef struct packed {addr_t addr; id_t id; len_t len;} ar_chan_t;
  typedef struct packed {addr_t addr; id_t id; len_t len;} aw_chan_t;

  // Burst end comes from the AW length, so no last flag here
  typedef struct packed {data_t data; strb_t strb;} w_chan_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    logic  last;
  } r_chan_t;

  // Response is always OKAY
  typedef struct packed {id_t id;} b_chan_t;

endpackage

`default_nettype wire
